// File: tb.f
src/ssb_pkg.sv
src/fiq_interp.sv
src/flevel_set.sv
src/afterburner.sv
src/lo_gen.sv
src/ssb_regs.sv
src/ssb_out.sv
src/ssb_top.sv
bench/ssb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the SSB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module ssb_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vssb_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0

// File: bench/ssb_tb.sv
`timescale 1ns/100ps

module ssb_tb;

	// Settle counts the cycles before the first compare of a row
	typedef struct packed {
		logic enable;
		logic [15:0] coeff;
		logic [7:0] phstep;
		logic signed [17:0] drv_i;
		logic signed [17:0] drv_q;
		logic [7:0] settle;
		logic rnd;
	} row_t;

	localparam int N_ROWS = 8;
	// Compared cycles per row cover one full LO period at phstep 16
	localparam int N_CHK = 16;

	// Muted rows, fixed LO rows, moving LO rows, then one random row
	localparam row_t ROWS [N_ROWS] = '{
		'{1'b0, 16'd18646, 8'd0, 18'sd60000, -18'sd70000, 8'd10, 1'b0},
		'{1'b0, 16'd18646, 8'd5, 18'sd131071, 18'h20000, 8'd10, 1'b0},
		'{1'b1, 16'd32768, 8'd0, 18'sd40000, -18'sd24000, 8'd10, 1'b0},
		'{1'b1, 16'd18646, 8'd0, 18'sd100000, -18'sd100000, 8'd10, 1'b0},
		'{1'b1, 16'd65535, 8'd0, 18'sd131071, 18'h20000, 8'd10, 1'b0},
		'{1'b1, 16'd18646, 8'd16, 18'sd80000, 18'sd30000, 8'd10, 1'b0},
		'{1'b1, 16'd32768, 8'd37, -18'sd90000, 18'sd110000, 8'd10, 1'b0},
		'{1'b1, 16'd65535, 8'd0, 18'sd0, 18'sd0, 8'd10, 1'b1}
	};

	logic clk;
	logic i_rst_n;
	ssb_pkg::wb_req_t wb_req;
	ssb_pkg::wb_rsp_t o_wb;
	logic signed [17:0] i_drive;
	logic i_iq;
	ssb_pkg::dac_pair_t o_dac1;
	ssb_pkg::dac_pair_t o_dac2;

	// Current drive words alternate onto i_drive
	logic signed [17:0] cur_i;
	logic signed [17:0] cur_q;
	// Model LO history where entry k is the LO value k edges ago
	logic [7:0] m_phase;
	logic [7:0] m_phstep;
	ssb_pkg::lo_t lo_hist [6];

	integer seed;
	int cycles = 0;
	int limit;

	ssb_top dut_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_wb(wb_req), .o_wb(o_wb),
		.i_drive(i_drive), .i_iq(i_iq),
		.o_dac1(o_dac1), .o_dac2(o_dac2)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Sum of reset, register accesses at three cycles each, rows and margin
	function automatic int run_limit();
		int r;
		int total;
		total = 3 + 12 * 3 + 40;
		for (r = 0; r < N_ROWS; r++)
			total += ROWS[r].settle + N_CHK + 3 * 3;
		return total;
	endfunction

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Done: errors found");
			$fatal(1, "Run timed out after %0d cycles", cycles);
		end
	end

	task automatic expect_equal(input logic signed [31:0] got, input logic signed [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Advance one clock, then drive 2 ns after the edge
	task automatic next_cycle();
		int k;
		logic [ssb_pkg::LO_IDX_W-1:0] slot;
		@(posedge clk);
		#2;
		for (k = 5; k > 0; k--)
			lo_hist[k] = lo_hist[k-1];
		// LO after this edge comes from the phase before it
		slot = m_phase[ssb_pkg::LO_PH_W-1 -: ssb_pkg::LO_IDX_W];
		lo_hist[0].cos = ssb_pkg::LO_COS[slot];
		lo_hist[0].sin = ssb_pkg::LO_SIN[slot];
		// A zero step parks the phase on slot 0
		if (m_phstep == 0)
			m_phase = '0;
		else
			m_phase = m_phase + m_phstep;
		i_iq = ~i_iq;
		i_drive = i_iq ? cur_i : cur_q;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
		next_cycle();
		while (!o_wb.ack)
			next_cycle();
		wb_req = '0;
		// New step counts from the next edge on
		if (addr == ssb_pkg::REG_PHSTEP)
			m_phstep = data[7:0];
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 16'd0};
		next_cycle();
		while (!o_wb.ack)
			next_cycle();
		data = o_wb.dat;
		wb_req = '0;
	endtask

	function automatic int clamp16(input longint v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return int'(v);
	endfunction

	// Dot product against one LO sample with the full-scale weight removed
	function automatic int level_out(input int a, input int b, input ssb_pkg::lo_t lo);
		longint acc;
		acc = longint'(a) * longint'(lo.cos) + longint'(b) * longint'(lo.sin);
		return clamp16(acc >>> 17);
	endfunction

	// Quadrature path sees Q and the inverted I
	function automatic int path_level(input bit quad, input bit en, input int i17,
			input int q17, input ssb_pkg::lo_t lo);
		if (!en)
			return 0;
		if (quad)
			return level_out(q17, -i17 - 1, lo);
		return level_out(i17, q17, lo);
	endfunction

	// Midpoint of two samples with an unsigned Q16 coefficient
	function automatic int mid_out(input int sum, input int coeff);
		return clamp16((longint'(sum) * longint'(coeff)) >>> 16);
	endfunction

	initial begin
		logic [15:0] rd;
		row_t row;
		ssb_pkg::dac_pair_t pair;
		ssb_pkg::lo_t lo_now;
		ssb_pkg::lo_t lo_prev;
		int r;
		int n;
		int p;
		int i17;
		int q17;
		int x0;
		int x1;
		seed = 32'h2549_ea1c;
		wb_req = '0;
		i_drive = '0;
		i_iq = 1'b0;
		i_rst_n = 1'b0;
		cur_i = '0;
		cur_q = '0;
		m_phase = '0;
		m_phstep = '0;
		for (r = 0; r < 6; r++)
			lo_hist[r] = '{cos: ssb_pkg::LO_COS[0], sin: ssb_pkg::LO_SIN[0]};
		limit = run_limit();
		repeat (3) @(posedge clk);
		#2;
		i_rst_n = 1'b1;

		expect_equal(o_dac1, 0, "dac1 after reset");
		expect_equal(o_dac2, 0, "dac2 after reset");
		// Reset values, then write and read back each register
		read_reg(ssb_pkg::REG_CTRL, rd);
		expect_equal(rd, 0, "CTRL reset value");
		read_reg(ssb_pkg::REG_COEFF, rd);
		expect_equal(rd, 18646, "COEFF reset value");
		read_reg(ssb_pkg::REG_PHSTEP, rd);
		expect_equal(rd, 0, "PHSTEP reset value");
		read_reg(ssb_pkg::REG_ID, rd);
		expect_equal(rd, ssb_pkg::SSB_ID, "ID value");
		write_reg(ssb_pkg::REG_CTRL, 16'd1);
		read_reg(ssb_pkg::REG_CTRL, rd);
		expect_equal(rd, 1, "CTRL readback");
		write_reg(ssb_pkg::REG_COEFF, 16'd12345);
		read_reg(ssb_pkg::REG_COEFF, rd);
		expect_equal(rd, 12345, "COEFF readback");
		write_reg(ssb_pkg::REG_PHSTEP, 16'h00a5);
		read_reg(ssb_pkg::REG_PHSTEP, rd);
		expect_equal(rd, 165, "PHSTEP readback");
		// ID is read only
		write_reg(ssb_pkg::REG_ID, 16'h1234);
		read_reg(ssb_pkg::REG_ID, rd);
		expect_equal(rd, ssb_pkg::SSB_ID, "ID after write");

		for (r = 0; r < N_ROWS; r++) begin
			row = ROWS[r];
			if (row.rnd) begin
				cur_i = $random(seed);
				cur_q = $random(seed);
			end else begin
				cur_i = row.drv_i;
				cur_q = row.drv_q;
			end
			write_reg(ssb_pkg::REG_CTRL, {15'd0, row.enable});
			write_reg(ssb_pkg::REG_COEFF, row.coeff);
			write_reg(ssb_pkg::REG_PHSTEP, {8'd0, row.phstep});
			repeat (row.settle) next_cycle();
			// Interpolator keeps the top 16 drive bits
			i17 = int'(cur_i) >>> 2;
			q17 = int'(cur_q) >>> 2;
			for (n = 0; n < N_CHK; n++) begin
				next_cycle();
				// LO to DAC takes 4 edges and the midpoint also needs the sample before
				if (row.phstep == 0) begin
					// Zero step holds the LO at full-scale cos and zero sin
					lo_now = '{cos: 18'sd131071, sin: 18'sd0};
					lo_prev = lo_now;
				end else begin
					lo_now = lo_hist[4];
					lo_prev = lo_hist[5];
				end
				for (p = 0; p < 2; p++) begin
					x0 = path_level(p == 1, row.enable, i17, q17, lo_now);
					x1 = path_level(p == 1, row.enable, i17, q17, lo_prev);
					pair = (p == 1) ? o_dac2 : o_dac1;
					expect_equal($signed(pair.out0), x0,
						$sformatf("row %0d dac%0d out0", r, p + 1));
					expect_equal($signed(pair.out1), mid_out(x0 + x1, row.coeff),
						$sformatf("row %0d dac%0d out1", r, p + 1));
				end
			end
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: src/ssb_top.sv
`timescale 1ns/100ps

module ssb_top (
	input  logic                               clk,
	input  logic                               i_rst_n,
	// Register bus
	input  ssb_pkg::wb_req_t                   i_wb,
	output ssb_pkg::wb_rsp_t                   o_wb,
	// Interleaved baseband, i_iq high on I words
	input  logic signed [ssb_pkg::DRIVE_W-1:0] i_drive,
	input  logic                               i_iq,
	// DDR pairs for the two DACs
	output ssb_pkg::dac_pair_t                 o_dac1,
	output ssb_pkg::dac_pair_t                 o_dac2
);

	ssb_pkg::ssb_cfg_t cfg;
	ssb_pkg::lo_t lo;

	ssb_regs u_regs (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_wb(i_wb), .o_wb(o_wb),
		.o_cfg(cfg)
	);

	// On-chip LO, frequency set by the phase step
	lo_gen u_lo (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_phstep(cfg.phstep),
		.o_lo(lo)
	);

	ssb_out #(
		.IQ_OUT(1)
	) u_ssb (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_drive(i_drive), .i_iq(i_iq),
		.i_lo(lo), .i_cfg(cfg),
		.o_dac1(o_dac1), .o_dac2(o_dac2)
	);

endmodule

// File: src/ssb_out.sv
`timescale 1ns/100ps

module ssb_out #(
	// 1 builds both DAC paths, 0 only the in-phase one
	parameter int IQ_OUT = 1
) (
	input  logic                               clk,
	input  logic                               i_rst_n,
	input  logic signed [ssb_pkg::DRIVE_W-1:0] i_drive,
	input  logic                               i_iq,
	input  ssb_pkg::lo_t                       i_lo,
	input  ssb_pkg::ssb_cfg_t                  i_cfg,
	output ssb_pkg::dac_pair_t                 o_dac1,
	output ssb_pkg::dac_pair_t                 o_dac2
);

	// Full-rate baseband
	logic signed [16:0] drive_i;
	logic signed [16:0] drive_q;

	// In-phase path
	logic signed [ssb_pkg::DAC_W-1:0] level1;
	logic signed [ssb_pkg::DAC_W-1:0] gated1;
	logic [ssb_pkg::DAC_W-1:0] ob1_0;
	logic [ssb_pkg::DAC_W-1:0] ob1_1;

	fiq_interp u_interp (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_drive(i_drive), .i_iq(i_iq),
		.o_i(drive_i), .o_q(drive_q)
	);

	// Hartley modulator, I.cos + Q.sin picks the sideband
	flevel_set u_level1 (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_i(drive_i), .i_q(drive_q), .i_lo(i_lo),
		.o_data(level1)
	);

	// Output muted while disabled
	assign gated1 = i_cfg.enable ? level1 : '0;

	afterburner u_aftb1 (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_data(gated1), .i_coeff(i_cfg.coeff),
		.o_ob0(ob1_0), .o_ob1(ob1_1)
	);

	// Back to two's complement
	assign o_dac1.out0 = {~ob1_0[15], ob1_0[14:0]};
	assign o_dac1.out1 = {~ob1_1[15], ob1_1[14:0]};

	if (IQ_OUT != 0) begin : g_iq
		logic signed [ssb_pkg::DAC_W-1:0] level2;
		logic signed [ssb_pkg::DAC_W-1:0] gated2;
		logic [ssb_pkg::DAC_W-1:0] ob2_0;
		logic [ssb_pkg::DAC_W-1:0] ob2_1;

		// Drive rotated by 90 degrees gives the quadrature component
		flevel_set u_level2 (
			.clk(clk), .i_rst_n(i_rst_n),
			.i_i(drive_q), .i_q(~drive_i), .i_lo(i_lo),
			.o_data(level2)
		);

		assign gated2 = i_cfg.enable ? level2 : '0;

		afterburner u_aftb2 (
			.clk(clk), .i_rst_n(i_rst_n),
			.i_data(gated2), .i_coeff(i_cfg.coeff),
			.o_ob0(ob2_0), .o_ob1(ob2_1)
		);

		assign o_dac2.out0 = {~ob2_0[15], ob2_0[14:0]};
		assign o_dac2.out1 = {~ob2_1[15], ob2_1[14:0]};
	end else begin : g_single
		// Single DAC build
		assign o_dac2 = '0;
	end

	// Midpoint uses two samples, so two muted samples silence both DACs
	a_mute: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		(!$past(i_cfg.enable, 2) && !$past(i_cfg.enable, 3))
			|-> (o_dac1 == '0 && o_dac2 == '0)
	);

endmodule

// File: src/ssb_regs.sv
`timescale 1ns/100ps

module ssb_regs (
	input  logic               clk,
	input  logic               i_rst_n,
	input  ssb_pkg::wb_req_t   i_wb,
	output ssb_pkg::wb_rsp_t   o_wb,
	output ssb_pkg::ssb_cfg_t  o_cfg
);

	ssb_pkg::ssb_reg_e adr;
	// New request, a held strobe during ack does not count twice
	logic req;

	logic r_ack;
	logic [15:0] r_dat;
	ssb_pkg::ssb_cfg_t r_cfg;

	assign adr = ssb_pkg::ssb_reg_e'(i_wb.adr);
	assign req = i_wb.cyc & i_wb.stb & ~r_ack;

	// Zero wait states, ack on the edge after the request
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_ack <= 1'b0;
			r_cfg.enable <= 1'b0;
			r_cfg.coeff <= ssb_pkg::AFTB_COEFF_RST;
			r_cfg.phstep <= '0;
		end else begin
			r_ack <= req;
			if (req && i_wb.we) begin
				case (adr)
					ssb_pkg::REG_CTRL: r_cfg.enable <= i_wb.dat[0];
					ssb_pkg::REG_COEFF: r_cfg.coeff <= i_wb.dat;
					ssb_pkg::REG_PHSTEP: r_cfg.phstep <= i_wb.dat[ssb_pkg::LO_PH_W-1:0];
					// ID is read only
					default: ;
				endcase
			end
		end
	end

	// Read mux, only looked at while ack is high
	always_ff @(posedge clk) begin
		if (req && !i_wb.we) begin
			case (adr)
				ssb_pkg::REG_CTRL: r_dat <= {15'd0, r_cfg.enable};
				ssb_pkg::REG_COEFF: r_dat <= r_cfg.coeff;
				ssb_pkg::REG_PHSTEP: r_dat <= {8'd0, r_cfg.phstep};
				default: r_dat <= ssb_pkg::SSB_ID;
			endcase
		end
	end

	assign o_wb.ack = r_ack;
	assign o_wb.dat = r_dat;
	assign o_cfg = r_cfg;

	// Single-cycle ack even if the master is slow to drop stb
	a_ack_pulse: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		(o_wb.ack && i_wb.stb) |=> !o_wb.ack
	);

	// No ack without a request on the edge before
	a_ack_after_req: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		o_wb.ack |-> $past(i_wb.cyc && i_wb.stb)
	);

endmodule

// File: src/lo_gen.sv
`timescale 1ns/100ps

module lo_gen (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  logic [ssb_pkg::LO_PH_W-1:0] i_phstep,
	output ssb_pkg::lo_t                o_lo
);

	// Phase in 1/256 turns
	logic [ssb_pkg::LO_PH_W-1:0] r_phase;
	// Table slot from the top of the phase
	logic [ssb_pkg::LO_IDX_W-1:0] idx;

	ssb_pkg::lo_t r_lo;

	assign idx = r_phase[ssb_pkg::LO_PH_W-1 -: ssb_pkg::LO_IDX_W];

	// Accumulator wraps once per LO period
	// A zero step parks the phase on slot 0
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_phase <= '0;
		else if (i_phstep == '0)
			r_phase <= '0;
		else
			r_phase <= r_phase + i_phstep;
	end

	// Registered lookup runs one cycle behind the phase
	// Slot 0 has cos at full scale and sin at 0
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_lo.cos <= ssb_pkg::LO_COS[0];
			r_lo.sin <= ssb_pkg::LO_SIN[0];
		end else begin
			r_lo.cos <= ssb_pkg::LO_COS[idx];
			r_lo.sin <= ssb_pkg::LO_SIN[idx];
		end
	end

	assign o_lo = r_lo;

endmodule

// File: src/afterburner.sv
`timescale 1ns/100ps

module afterburner (
	input  logic                             clk,
	input  logic                             i_rst_n,
	input  logic signed [ssb_pkg::DAC_W-1:0] i_data,
	input  logic [15:0]                      i_coeff,
	output logic [ssb_pkg::DAC_W-1:0]        o_ob0,
	output logic [ssb_pkg::DAC_W-1:0]        o_ob1
);

	// Current sample, the one before sits in the register until replaced
	logic signed [ssb_pkg::DAC_W-1:0] r_cur;
	// Current plus previous, one bit of headroom
	logic signed [16:0] r_sum;

	// Midpoint path
	logic signed [33:0] mid_prod;
	logic signed [17:0] mid_sh;
	logic signed [ssb_pkg::DAC_W-1:0] mid_sat;

	logic [ssb_pkg::DAC_W-1:0] r_ob0;
	logic [ssb_pkg::DAC_W-1:0] r_ob1;

	// Stage one
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cur <= '0;
			r_sum <= '0;
		end else begin
			r_cur <= i_data;
			// r_cur still holds the previous sample here
			r_sum <= i_data + r_cur;
		end
	end

	// Coefficient is unsigned Q16
	// 32768 turns the sum into a plain average
	assign mid_prod = r_sum * $signed({1'b0, i_coeff});
	assign mid_sh = mid_prod[33:16];
	assign mid_sat = ssb_pkg::sat_dac({{2{mid_sh[17]}}, mid_sh});

	// Stage two, offset binary by flipping the sign bit
	// Reset value is the offset-binary code for zero
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_ob0 <= 16'h8000;
			r_ob1 <= 16'h8000;
		end else begin
			r_ob0 <= {~r_cur[15], r_cur[14:0]};
			r_ob1 <= {~mid_sat[15], mid_sat[14:0]};
		end
	end

	assign o_ob0 = r_ob0;
	assign o_ob1 = r_ob1;

endmodule

// File: src/flevel_set.sv
`timescale 1ns/100ps

module flevel_set (
	input  logic                             clk,
	input  logic                             i_rst_n,
	input  logic signed [16:0]               i_i,
	input  logic signed [16:0]               i_q,
	input  ssb_pkg::lo_t                     i_lo,
	output logic signed [ssb_pkg::DAC_W-1:0] o_data
);

	// 17 x 18 bit products
	logic signed [34:0] r_prod_i;
	logic signed [34:0] r_prod_q;

	// Dot product and its scaled form
	logic signed [35:0] dot;
	logic signed [18:0] dot_sh;

	logic signed [ssb_pkg::DAC_W-1:0] r_data;

	// Stage one, I against cos and Q against sin
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_prod_i <= '0;
			r_prod_q <= '0;
		end else begin
			r_prod_i <= i_i * i_lo.cos;
			r_prod_q <= i_q * i_lo.sin;
		end
	end

	assign dot = r_prod_i + r_prod_q;
	// Drop the LO full-scale weight
	assign dot_sh = dot[35:17];

	// Stage two, clamp to the DAC word
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_data <= '0;
		else
			r_data <= ssb_pkg::sat_dac({dot_sh[18], dot_sh});
	end

	assign o_data = r_data;

	// Zero drive must come out as exact zero, no rounding offset
	a_zero_in_zero_out: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		($past(i_i, 2) == '0 && $past(i_q, 2) == '0) |-> (o_data == '0)
	);

endmodule

// File: src/fiq_interp.sv
`timescale 1ns/100ps

module fiq_interp (
	input  logic                               clk,
	input  logic                               i_rst_n,
	input  logic signed [ssb_pkg::DRIVE_W-1:0] i_drive,
	input  logic                               i_iq,
	output logic signed [16:0]                 o_i,
	output logic signed [16:0]                 o_q
);

	// Top 16 drive bits, sign extended by one
	logic signed [16:0] drive_top;

	logic signed [16:0] r_i;
	logic signed [16:0] r_q;

	assign drive_top = {i_drive[ssb_pkg::DRIVE_W-1], i_drive[ssb_pkg::DRIVE_W-1 -: 16]};

	// Each channel is sampled in its own slot and held through the other
	// so both run at the full clock rate
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_i <= '0;
			r_q <= '0;
		end else begin
			// I slot
			if (i_iq)
				r_i <= drive_top;
			// Q slot
			if (!i_iq)
				r_q <= drive_top;
		end
	end

	assign o_i = r_i;
	assign o_q = r_q;

endmodule

// File: src/ssb_pkg.sv
package ssb_pkg;

	// Datapath widths
	localparam int DRIVE_W = 18;
	localparam int DAC_W = 16;
	// Phase accumulator and table index
	localparam int LO_PH_W = 8;
	localparam int LO_IDX_W = 4;

	// Midpoint correction for the interpolator, 0.569 in Q16
	localparam logic [15:0] AFTB_COEFF_RST = 16'd18646;
	// Fixed value returned from the ID register
	localparam logic [15:0] SSB_ID = 16'h55b1;

	// One LO period in 16 steps, full scale 131071
	localparam logic signed [DRIVE_W-1:0] LO_COS [2**LO_IDX_W] = '{
		18'sd131071, 18'sd121094, 18'sd92681, 18'sd50159,
		18'sd0, -18'sd50159, -18'sd92681, -18'sd121094,
		-18'sd131071, -18'sd121094, -18'sd92681, -18'sd50159,
		18'sd0, 18'sd50159, 18'sd92681, 18'sd121094
	};
	// Same period, a quarter turn behind
	localparam logic signed [DRIVE_W-1:0] LO_SIN [2**LO_IDX_W] = '{
		18'sd0, 18'sd50159, 18'sd92681, 18'sd121094,
		18'sd131071, 18'sd121094, 18'sd92681, 18'sd50159,
		18'sd0, -18'sd50159, -18'sd92681, -18'sd121094,
		-18'sd131071, -18'sd121094, -18'sd92681, -18'sd50159
	};

	// Wishbone register map
	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_COEFF = 2'd1,
		REG_PHSTEP = 2'd2,
		REG_ID = 2'd3
	} ssb_reg_e;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] adr;
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// Run-time settings from the register bank
	typedef struct packed {
		logic enable;
		logic [15:0] coeff;
		logic [LO_PH_W-1:0] phstep;
	} ssb_cfg_t;

	typedef struct packed {
		logic signed [DRIVE_W-1:0] cos;
		logic signed [DRIVE_W-1:0] sin;
	} lo_t;

	// One DDR sample pair, out0 goes first
	typedef struct packed {
		logic signed [DAC_W-1:0] out0;
		logic signed [DAC_W-1:0] out1;
	} dac_pair_t;

	// Clamp a wide signed value to the DAC range
	function automatic logic signed [DAC_W-1:0] sat_dac(input logic signed [19:0] v);
		if (v > 20'sd32767)
			return 16'sh7fff;
		if (v < -20'sd32768)
			return -16'sh8000;
		return v[DAC_W-1:0];
	endfunction

endpackage
